/* compile.f */
verilog/mipsPkg.sv
verilog/aluUnit.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/pcUnit.sv
verilog/mipsExecCore.sv
tb/mipsExecTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module mipsExecTb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "STATUS: PASS" \
	|| { echo "Simulation did not pass"; exit 1; }

/* tb/execStimulus.txt */
# name valid instr wbValid wbAddr wbData pc
# instr, wbData and pc in hex, the others in decimal
addi_r1 1 20010005 1 1 00000005 00400004
addi_neg 1 2002FFFD 1 2 FFFFFFFD 00400008
lui_r3 1 3C031234 1 3 12340000 0040000C
addi_r0 1 20200007 1 0 0000000C 00400010
add_r0r0 1 00002020 1 4 00000000 00400014
add 1 00222820 1 5 00000002 00400018
sub 1 00223022 1 6 00000008 0040001C
mul 1 70223802 1 7 FFFFFFF1 00400020
and 1 00224024 1 8 00000005 00400024
or 1 00614825 1 9 12340005 00400028
nor 1 00205027 1 10 FFFFFFFA 0040002C
xor 1 00625826 1 11 EDCBFFFD 00400030
andi 1 304CF0F0 1 12 0000F0F0 00400034
ori 1 346D8001 1 13 12348001 00400038
xori 1 384EFFFF 1 14 FFFF0002 0040003C
sll 1 00017900 1 15 00000050 00400040
srl 1 00028202 1 16 00FFFFFF 00400044
slt_neg 1 0041882A 1 17 00000001 00400048
slt_pos 1 0022902A 1 18 00000000 0040004C
slti_neg 1 2853FFFE 1 19 00000001 00400050
idle 0 20010063 0 0 00000000 00400050
beq_taken 1 10210002 0 0 00000000 0040005C
beq_not 1 10220002 0 0 00000000 00400060
bne_taken 1 14220001 0 0 00000000 00400068
bne_not 1 14210001 0 0 00000000 0040006C
bgez_neg 1 04410003 0 0 00000000 00400070
bgez_zero 1 04810001 0 0 00000000 00400078
bltz_back 1 0440FFFE 0 0 00000000 00400074
bltz_pos 1 04200001 0 0 00000000 00400078
bgtz_pos 1 1C200003 0 0 00000000 00400088
bgtz_zero 1 1C800003 0 0 00000000 0040008C
blez_zero 1 18800001 0 0 00000000 00400094
blez_pos 1 18200001 0 0 00000000 00400098
blez_neg 1 18400002 0 0 00000000 004000A4
jal 1 0C100040 1 31 004000A8 00400100
j 1 08100080 0 0 00000000 00400200
jr_r31 1 03E00008 0 0 00000000 004000A8
add_link 1 03E0A020 1 20 004000A8 004000AC

/* tb/mipsExecTb.sv */
module mipsExecTb;

	timeunit 1ns;
	timeprecision 100ps;

	import mipsPkg::*;

	localparam word_t ResetPc = 32'h0040_0000;
	localparam string StimFile = "tb/execStimulus.txt";

	//////////////////////////////
	// DUT signals
	//////////////////////////////

	logic clk;
	logic rstN;
	logic valid;
	word_t instr;
	logic wbValid;
	regAddr_t wbAddr;
	word_t wbData;
	word_t pc;

	// Drive and expect fields of one stimulus line
	typedef struct packed {
		logic valid;
		word_t instr;
		logic wbFlag;
		regAddr_t wbAddr;
		word_t wbData;
		word_t pc;
	} vector_t;

	vector_t vectors[$];
	string names[$];
	int errors = 0;
	int checks = 0;
	bit loaded = 1'b0;

	mipsExecCore #(
		.resetPc(ResetPc)
	) uut (
		.clk(clk),
		.rstN(rstN),
		.valid(valid),
		.instr(instr),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.pc(pc)
	);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Parse the stimulus file into the vector queues
	task automatic loadVectors(output bit ok);
		int fd;
		int n;
		int v;
		int wf;
		int ra;
		string line;
		string name;
		word_t ins;
		word_t wd;
		word_t pcExp;
		vector_t vec;
		ok = 1'b0;
		fd = $fopen(StimFile, "r");
		if (fd == 0)
			return;
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// Comments and blank lines
			if (n <= 1 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %d %h %d %d %h %h", name, v, ins, wf, ra, wd, pcExp);
			if (n != 7) begin
				errors++;
				$display("Stimulus line could not be parsed: %s", line);
				continue;
			end
			vec.valid = v[0];
			vec.instr = ins;
			vec.wbFlag = wf[0];
			vec.wbAddr = ra[4:0];
			vec.wbData = wd;
			vec.pc = pcExp;
			vectors.push_back(vec);
			names.push_back(name);
		end
		$fclose(fd);
		ok = (vectors.size() > 0);
	endtask

	task automatic checkWord(input string name, input string what,
			input word_t expected, input word_t actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
		end
	endtask

	// Drive on a falling edge, check one cycle later
	task automatic applyVector(input string name, input vector_t vec);
		valid = vec.valid;
		instr = vec.instr;
		@(negedge clk);
		checkWord(name, "wbValid", {31'd0, vec.wbFlag}, {31'd0, wbValid});
		// Report fields only mean something with wbValid high
		if (vec.wbFlag) begin
			checkWord(name, "wbAddr", {27'd0, vec.wbAddr}, {27'd0, wbAddr});
			checkWord(name, "wbData", vec.wbData, wbData);
		end
		checkWord(name, "pc", vec.pc, pc);
	endtask

	task automatic runTests();
		// State straight out of reset
		checkWord("reset", "wbValid", 32'd0, {31'd0, wbValid});
		checkWord("reset", "pc", ResetPc, pc);
		foreach (vectors[i]) begin
			applyVector(names[i], vectors[i]);
		end
		valid = 1'b0;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		bit ok;
		rstN = 1'b0;
		valid = 1'b0;
		instr = '0;
		loadVectors(ok);
		if (!ok) begin
			$display("Stimulus file %s is missing or holds no vectors", StimFile);
			$display("STATUS: FAIL");
		end else begin
			loaded = 1'b1;
			// Reset held for 8 cycles
			repeat (8) @(posedge clk);
			@(negedge clk);
			rstN = 1'b1;
			runTests();
			$display("Checks: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
		end
		$finish;
	end

	// Watchdog, sized from the vector count
	initial begin
		int limitNs;
		wait (loaded);
		// Reset cycles plus one cycle per vector, then slack
		limitNs = (10 + vectors.size()) * 10 + 200;
		#(limitNs);
		$display("Timeout after %0d ns, the test sequence did not finish", limitNs);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* verilog/mipsExecCore.sv */
module mipsExecCore #(
	parameter mipsPkg::word_t resetPc = 32'h0040_0000
) (
	input logic clk,
	input logic rstN,
	input logic valid,
	input mipsPkg::word_t instr,
	output logic wbValid,
	output mipsPkg::regAddr_t wbAddr,
	output mipsPkg::word_t wbData,
	output mipsPkg::word_t pc
);

	import mipsPkg::*;

	decode_t dec;
	aluIn_t aluIn;
	word_t rsVal;
	word_t rtVal;
	word_t immExt;
	word_t aluResult;
	logic aluZero;
	logic wrEn;
	logic cmpZero;

	instrDecoder uDecoder (
		.instr(instr),
		.dec(dec)
	);

	regFile uRegs (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(instr[25:21]),
		.rdAddrB(instr[20:16]),
		.rdDataA(rsVal),
		.rdDataB(rtVal),
		.wrEn(wrEn),
		.wrAddr(dec.dest),
		.wrData(aluResult)
	);

	//////////////////////////////
	// Operand selection
	//////////////////////////////

	assign immExt = dec.immZeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	// Compare-with-zero branches subtract zero from rs
	assign cmpZero = dec.branch inside {brGez, brGtz, brLez, brLtz};

	always_comb begin
		aluIn.op = dec.aluOp;
		case (dec.aSrc)
			aPc:
				aluIn.a = pc;
			aShamt:
				aluIn.a = {27'd0, instr[10:6]};
			default:
				aluIn.a = rsVal;
		endcase
		// jal computes the link as pc + 4
		if (dec.aSrc == aPc)
			aluIn.b = 32'd4;
		else if (cmpZero)
			aluIn.b = '0;
		else if (dec.useImm)
			aluIn.b = immExt;
		else
			aluIn.b = rtVal;
	end

	aluUnit uAlu (
		.in(aluIn),
		.result(aluResult),
		.zero(aluZero)
	);

	pcUnit #(
		.resetPc(resetPc)
	) uPc (
		.clk(clk),
		.rstN(rstN),
		.valid(valid),
		.branch(dec.branch),
		.zero(aluZero),
		.sign(aluResult[31]),
		.rsVal(rsVal),
		.imm16(instr[15:0]),
		.target26(instr[25:0]),
		.pc(pc),
		.pcPlus4()
	);

	//////////////////////////////
	// Writeback
	//////////////////////////////

	assign wrEn = valid && dec.regWrite;

	// One-cycle report of each register write
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			wbValid <= 1'b0;
		else
			wbValid <= wrEn;
	end

	// Link for jal is the ALU result too
	always_ff @(posedge clk) begin
		if (wrEn) begin
			wbAddr <= dec.dest;
			wbData <= aluResult;
		end
	end

endmodule

/* verilog/pcUnit.sv */
module pcUnit #(
	parameter mipsPkg::word_t resetPc = 32'h0040_0000
) (
	input logic clk,
	input logic rstN,
	input logic valid,
	input mipsPkg::branchKind_t branch,
	input logic zero,
	input logic sign,
	input mipsPkg::word_t rsVal,
	input logic [15:0] imm16,
	input logic [25:0] target26,
	output mipsPkg::word_t pc,
	output mipsPkg::word_t pcPlus4
);

	import mipsPkg::*;

	logic taken;
	word_t branchPc;
	word_t nextPc;

	assign pcPlus4 = pc + 32'd4;

	// Word offset, sign-extended
	assign branchPc = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};

	// Conditions from the rs - rt or rs - 0 result
	always_comb begin
		case (branch)
			brEq:
				taken = zero;
			brNe:
				taken = !zero;
			brGez:
				taken = !sign;
			brGtz:
				taken = !sign && !zero;
			brLez:
				taken = sign || zero;
			brLtz:
				taken = sign;
			default:
				taken = 1'b0;
		endcase
	end

	always_comb begin
		case (branch)
			// Region of the next instruction
			brJump:
				nextPc = {pcPlus4[31:28], target26, 2'b00};
			brJumpReg:
				nextPc = rsVal;
			default:
				nextPc = taken ? branchPc : pcPlus4;
		endcase
	end

	// Advance only on a valid instruction
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= resetPc;
		else if (valid)
			pc <= nextPc;
	end

endmodule

/* verilog/regFile.sv */
module regFile (
	input logic clk,
	input logic rstN,
	input mipsPkg::regAddr_t rdAddrA,
	input mipsPkg::regAddr_t rdAddrB,
	output mipsPkg::word_t rdDataA,
	output mipsPkg::word_t rdDataB,
	input logic wrEn,
	input mipsPkg::regAddr_t wrAddr,
	input mipsPkg::word_t wrData
);

	import mipsPkg::*;

	word_t regs [32];

	// Single write port
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			// Register 0 never written, so it stays zero
			regs[wrAddr] <= wrData;
		end
	end

	// Combinational reads
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

/* verilog/instrDecoder.sv */
module instrDecoder (
	input mipsPkg::word_t instr,
	output mipsPkg::decode_t dec
);

	import mipsPkg::*;

	// Primary opcodes
	localparam logic [5:0] OpSpecial = 6'h00;
	localparam logic [5:0] OpRegImm = 6'h01;
	localparam logic [5:0] OpJ = 6'h02;
	localparam logic [5:0] OpJal = 6'h03;
	localparam logic [5:0] OpBeq = 6'h04;
	localparam logic [5:0] OpBne = 6'h05;
	localparam logic [5:0] OpBlez = 6'h06;
	localparam logic [5:0] OpBgtz = 6'h07;
	localparam logic [5:0] OpAddi = 6'h08;
	localparam logic [5:0] OpSlti = 6'h0A;
	localparam logic [5:0] OpAndi = 6'h0C;
	localparam logic [5:0] OpOri = 6'h0D;
	localparam logic [5:0] OpXori = 6'h0E;
	localparam logic [5:0] OpLui = 6'h0F;
	localparam logic [5:0] OpSpecial2 = 6'h1C;

	// Function codes
	localparam logic [5:0] FnSll = 6'h00;
	localparam logic [5:0] FnSrl = 6'h02;
	localparam logic [5:0] FnJr = 6'h08;
	localparam logic [5:0] FnAdd = 6'h20;
	localparam logic [5:0] FnSub = 6'h22;
	localparam logic [5:0] FnAnd = 6'h24;
	localparam logic [5:0] FnOr = 6'h25;
	localparam logic [5:0] FnXor = 6'h26;
	localparam logic [5:0] FnNor = 6'h27;
	localparam logic [5:0] FnSlt = 6'h2A;
	// SPECIAL2 mul
	localparam logic [5:0] FnMul = 6'h02;

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t rt;
	regAddr_t rd;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	always_comb begin
		// No-op unless matched below
		dec.aluOp = opAdd;
		dec.aSrc = aReg;
		dec.useImm = 1'b0;
		dec.immZeroExt = 1'b0;
		dec.regWrite = 1'b0;
		dec.dest = rd;
		dec.branch = brNone;

		case (opcode)
			//////////////////////////////
			// R-type, by funct
			//////////////////////////////
			OpSpecial: begin
				dec.regWrite = 1'b1;
				case (funct)
					FnAdd:
						dec.aluOp = opAdd;
					FnSub:
						dec.aluOp = opSub;
					FnAnd:
						dec.aluOp = opAnd;
					FnOr:
						dec.aluOp = opOr;
					FnNor:
						dec.aluOp = opNor;
					FnXor:
						dec.aluOp = opXor;
					FnSlt:
						dec.aluOp = opSlt;
					FnSll: begin
						dec.aluOp = opSll;
						dec.aSrc = aShamt;
					end
					FnSrl: begin
						dec.aluOp = opSrl;
						dec.aSrc = aShamt;
					end
					// jr writes nothing
					FnJr: begin
						dec.regWrite = 1'b0;
						dec.branch = brJumpReg;
					end
					default:
						dec.regWrite = 1'b0;
				endcase
			end
			OpSpecial2: begin
				if (funct == FnMul) begin
					dec.aluOp = opMul;
					dec.regWrite = 1'b1;
				end
			end

			//////////////////////////////
			// Immediate ALU ops, write rt
			//////////////////////////////
			OpAddi, OpSlti, OpAndi, OpOri, OpXori, OpLui: begin
				dec.useImm = 1'b1;
				dec.regWrite = 1'b1;
				dec.dest = rt;
				// Logic ops and lui take the unsigned immediate
				dec.immZeroExt = (opcode inside {OpAndi, OpOri, OpXori, OpLui});
				case (opcode)
					OpSlti:
						dec.aluOp = opSlt;
					OpAndi:
						dec.aluOp = opAnd;
					OpOri:
						dec.aluOp = opOr;
					OpXori:
						dec.aluOp = opXor;
					OpLui:
						dec.aluOp = opLui;
					default:
						dec.aluOp = opAdd;
				endcase
			end

			// Branches, all on the subtraction
			OpBeq: begin
				dec.aluOp = opSub;
				dec.branch = brEq;
			end
			OpBne: begin
				dec.aluOp = opSub;
				dec.branch = brNe;
			end
			OpBlez: begin
				dec.aluOp = opSub;
				dec.branch = brLez;
			end
			OpBgtz: begin
				dec.aluOp = opSub;
				dec.branch = brGtz;
			end
			// rt selects bgez or bltz
			OpRegImm: begin
				dec.aluOp = opSub;
				if (rt == 5'd1)
					dec.branch = brGez;
				else if (rt == 5'd0)
					dec.branch = brLtz;
			end

			// Jumps
			OpJ:
				dec.branch = brJump;
			OpJal: begin
				dec.branch = brJump;
				dec.aSrc = aPc;
				dec.regWrite = 1'b1;
				dec.dest = 5'd31;
			end

			default:
				dec.regWrite = 1'b0;
		endcase
	end

endmodule

/* verilog/aluUnit.sv */
module aluUnit (
	input mipsPkg::aluIn_t in,
	output mipsPkg::word_t result,
	output logic zero
);

	import mipsPkg::*;

	//////////////////////////////
	// Operation select
	//////////////////////////////

	always_comb begin
		case (in.op)
			// Arithmetic
			opAdd:
				result = in.a + in.b;
			// Also used for all branch compares
			opSub:
				result = in.a - in.b;
			// Low 32 bits of the product
			opMul:
				result = in.a * in.b;

			// Logic
			opAnd:
				result = in.a & in.b;
			opOr:
				result = in.a | in.b;
			opNor:
				result = ~(in.a | in.b);
			opXor:
				result = in.a ^ in.b;

			// Shifts, amount in a, data in b
			opSll:
				result = in.b << in.a[4:0];
			opSrl:
				result = in.b >> in.a[4:0];

			// Signed compare, result 1 or 0
			opSlt:
				result = ($signed(in.a) < $signed(in.b)) ? 32'd1 : 32'd0;

			// Immediate into the upper half
			opLui:
				result = {in.b[15:0], 16'h0000};

			default:
				result = '0;
		endcase
	end

	// Zero flag, one compare for all ops
	assign zero = (result == '0);

endmodule

/* verilog/mipsPkg.sv */
package mipsPkg;

	//////////////////////////////
	// Word types
	//////////////////////////////

	// Data or address word
	typedef logic [31:0] word_t;

	// Register number
	typedef logic [4:0] regAddr_t;

	//////////////////////////////
	// Control encodings
	//////////////////////////////

	// ALU operations, one code per distinct function
	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opMul,
		opAnd,
		opOr,
		opNor,
		opXor,
		opSll,
		opSrl,
		opSlt,
		opLui
	} aluOp_t;

	// PC actions
	typedef enum logic [3:0] {
		brNone,
		brEq,
		brNe,
		brGez,
		brGtz,
		brLez,
		brLtz,
		brJump,
		brJumpReg
	} branchKind_t;

	// ALU A operand source
	typedef enum logic [1:0] {
		aReg,
		aPc,
		aShamt
	} aSrc_t;

	// Decoded control for one instruction
	typedef struct packed {
		aluOp_t aluOp;
		aSrc_t aSrc;
		logic useImm;
		logic immZeroExt;
		logic regWrite;
		regAddr_t dest;
		branchKind_t branch;
	} decode_t;

	// Operation and operands into the ALU
	typedef struct packed {
		aluOp_t op;
		word_t a;
		word_t b;
	} aluIn_t;

endpackage
